/* dv/clock_gen.sv */
`default_nettype none

module clock_gen #(
  parameter int PERIOD = 8
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* dv/matmul_tb.sv */
`default_nettype none

module matmul_tb;
  import matmul_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_TESTS      = 6;
  localparam int DONE_CYCLE     = WRITE_START + MAT_SIZE;
  localparam int RUN_CYCLES     = DONE_CYCLE + 1;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + RESET_CYCLES;
  localparam int MEM_WORDS      = 1024;
  localparam int BUSY_START_CYC = 2;

  typedef enum {PAT_IDENT, PAT_RANDOM, PAT_EXTREME} pattern_t;

  typedef struct {
    string    name;
    pattern_t a_pat;
    pattern_t b_pat;
    addr_t    base_a;
    addr_t    base_b;
    addr_t    base_c;
    bit       extra_start;
  } test_t;

  logic  clk;
  logic  reset    = 1'b1;
  logic  i_start  = 1'b0;
  addr_t i_base_a = '0;
  addr_t i_base_b = '0;
  addr_t i_base_c = '0;
  word_t a_rd_data = '0;
  word_t b_rd_data = '0;
  logic  o_rd_en;
  addr_t o_a_addr;
  addr_t o_b_addr;
  logic  o_c_valid;
  addr_t o_c_addr;
  word_t o_c_data;
  logic  o_busy;
  logic  o_done;

  word_t mem_a [MEM_WORDS];
  word_t mem_b [MEM_WORDS];
  elem_t mat_a [MAT_SIZE][MAT_SIZE];
  elem_t mat_b [MAT_SIZE][MAT_SIZE];
  elem_t ref_c [MAT_SIZE][MAT_SIZE];
  test_t tests [NUM_TESTS];

  int error_count  = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_count  = 0;

  clock_gen #(.PERIOD(8)) u_clk (.o_clk(clk));

  matmul_4x4_top DUT (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_base_a  (i_base_a),
    .i_base_b  (i_base_b),
    .i_base_c  (i_base_c),
    .i_a_data  (a_rd_data),
    .i_b_data  (b_rd_data),
    .o_rd_en   (o_rd_en),
    .o_a_addr  (o_a_addr),
    .o_b_addr  (o_b_addr),
    .o_c_valid (o_c_valid),
    .o_c_addr  (o_c_addr),
    .o_c_data  (o_c_data),
    .o_busy    (o_busy),
    .o_done    (o_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory models and run limit
  //////////////////////////////////////////////////////////////////////

  // One-cycle registered read that returns junk on idle cycles
  always @(posedge clk) begin
    if (o_rd_en) begin
      a_rd_data <= mem_a[o_a_addr];
      b_rd_data <= mem_b[o_b_addr];
    end else begin
      a_rd_data <= $urandom();
      b_rd_data <= $urandom();
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic elem_t sat_product(elem_t a, elem_t b);
    int p;
    p = int'(a) * int'(b);
    if (p > 127) begin
      return elem_t'(127);
    end else if (p < -128) begin
      return elem_t'(-128);
    end
    return elem_t'(p);
  endfunction

  // Extreme entries mix -128 and 127 so every sign pairing occurs
  function automatic elem_t pattern_elem(pattern_t pat, int row, int col, bit is_b);
    case (pat)
      PAT_IDENT: return (row == col) ? elem_t'(1) : elem_t'(0);
      PAT_EXTREME: begin
        if (is_b) begin
          return ((row + 2 * col) % 3 == 0) ? elem_t'(-128) : elem_t'(127);
        end
        return ((row + col) % 2 == 0) ? elem_t'(-128) : elem_t'(127);
      end
      default: return elem_t'($urandom());
    endcase
  endfunction

  function automatic word_t background(int addr, word_t salt);
    return (word_t'(addr) * 32'h9e37_79b9) ^ salt;
  endfunction

  // Word j holds column j of C with row i in lane i
  function automatic word_t expected_col(int j);
    word_t w;
    for (int i = 0; i < MAT_SIZE; i++) begin
      w[i*DATA_W +: DATA_W] = ref_c[i][j];
    end
    return w;
  endfunction

  task automatic prepare_test(test_t t);
    elem_t acc;
    word_t wa;
    word_t wb;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int k = 0; k < MAT_SIZE; k++) begin
        mat_a[i][k] = pattern_elem(t.a_pat, i, k, 1'b0);
        mat_b[i][k] = pattern_elem(t.b_pat, i, k, 1'b1);
      end
    end
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        acc = '0;
        for (int k = 0; k < MAT_SIZE; k++) begin
          acc = acc + sat_product(mat_a[i][k], mat_b[k][j]);
        end
        ref_c[i][j] = acc;
      end
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem_a[a] = background(a, 32'h0000_0000);
      mem_b[a] = background(a, 32'h5a5a_a5a5);
    end
    // A words hold columns of A and B words hold rows of B
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        wa[i*DATA_W +: DATA_W] = mat_a[i][k];
        wb[i*DATA_W +: DATA_W] = mat_b[k][i];
      end
      mem_a[addr_t'(t.base_a + k)] = wa;
      mem_b[addr_t'(t.base_b + k)] = wb;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and test sequencing
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED at time %0t: %s got 0x%0h, expected 0x%0h",
             $time, what, got, exp);
    error_count++;
  endtask

  // Control outputs stay low whenever no run is active
  task automatic check_idle(string when);
    if (o_busy !== 1'b0) begin
      report_mismatch({when, " o_busy"}, o_busy, 1'b0);
    end
    if (o_done !== 1'b0) begin
      report_mismatch({when, " o_done"}, o_done, 1'b0);
    end
    if (o_rd_en !== 1'b0) begin
      report_mismatch({when, " o_rd_en"}, o_rd_en, 1'b0);
    end
    if (o_c_valid !== 1'b0) begin
      report_mismatch({when, " o_c_valid"}, o_c_valid, 1'b0);
    end
  endtask

  task automatic check_cycle(test_t t, int cyc);
    logic  exp_rd;
    logic  exp_valid;
    logic  exp_busy;
    logic  exp_done;
    addr_t exp_addr;
    word_t exp_word;
    exp_rd    = (cyc >= 1) && (cyc <= MAT_SIZE);
    exp_valid = (cyc >= WRITE_START) && (cyc < DONE_CYCLE);
    exp_busy  = (cyc >= 1) && (cyc < DONE_CYCLE);
    exp_done  = (cyc == DONE_CYCLE);
    if (o_rd_en !== exp_rd) begin
      report_mismatch($sformatf("cycle %0d o_rd_en", cyc), o_rd_en, exp_rd);
    end
    if (exp_rd) begin
      exp_addr = addr_t'(t.base_a + cyc - 1);
      if (o_a_addr !== exp_addr) begin
        report_mismatch($sformatf("cycle %0d o_a_addr", cyc), o_a_addr, exp_addr);
      end
      exp_addr = addr_t'(t.base_b + cyc - 1);
      if (o_b_addr !== exp_addr) begin
        report_mismatch($sformatf("cycle %0d o_b_addr", cyc), o_b_addr, exp_addr);
      end
    end
    if (o_c_valid !== exp_valid) begin
      report_mismatch($sformatf("cycle %0d o_c_valid", cyc), o_c_valid, exp_valid);
    end
    if (exp_valid) begin
      exp_addr = addr_t'(t.base_c + cyc - WRITE_START);
      exp_word = expected_col(cyc - WRITE_START);
      if (o_c_addr !== exp_addr) begin
        report_mismatch($sformatf("cycle %0d o_c_addr", cyc), o_c_addr, exp_addr);
      end
      if (o_c_data !== exp_word) begin
        report_mismatch($sformatf("cycle %0d o_c_data", cyc), o_c_data, exp_word);
      end
    end
    if (o_busy !== exp_busy) begin
      report_mismatch($sformatf("cycle %0d o_busy", cyc), o_busy, exp_busy);
    end
    if (o_done !== exp_done) begin
      report_mismatch($sformatf("cycle %0d o_done", cyc), o_done, exp_done);
    end
  endtask

  // Next run starts in the cycle right after done
  task automatic run_test(test_t t);
    int errors_before;
    errors_before = error_count;
    prepare_test(t);
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(posedge clk);
      if (cyc == 0) begin
        i_start  <= 1'b1;
        i_base_a <= t.base_a;
        i_base_b <= t.base_b;
        i_base_c <= t.base_c;
      end else if (t.extra_start && (cyc == BUSY_START_CYC || cyc == DONE_CYCLE)) begin
        i_start  <= 1'b1;
        i_base_a <= ~t.base_a;
        i_base_b <= ~t.base_b;
        i_base_c <= ~t.base_c;
      end else begin
        i_start <= 1'b0;
      end
      @(negedge clk);
      check_cycle(t, cyc);
    end
    if (error_count == errors_before) begin
      $display("PASS: %s", t.name);
      tests_passed++;
    end else begin
      $display("FAIL: %s (%0d errors)", t.name, error_count - errors_before);
      tests_failed++;
    end
  endtask

  initial begin
    void'($urandom(32'hc500_313b));
    tests[0] = '{"identity_times_random_b", PAT_IDENT, PAT_RANDOM,
                 10'h010, 10'h020, 10'h030, 1'b0};
    tests[1] = '{"random_full_range", PAT_RANDOM, PAT_RANDOM,
                 10'h100, 10'h200, 10'h300, 1'b0};
    tests[2] = '{"extreme_saturation", PAT_EXTREME, PAT_EXTREME,
                 10'h3fe, 10'h005, 10'h3fd, 1'b0};
    tests[3] = '{"start_while_busy", PAT_RANDOM, PAT_RANDOM,
                 10'h040, 10'h080, 10'h0c0, 1'b1};
    tests[4] = '{"back_to_back_no_residue", PAT_IDENT, PAT_EXTREME,
                 10'h1f0, 10'h1f4, 10'h1f8, 1'b0};
    tests[5] = '{"random_second_pass", PAT_RANDOM, PAT_RANDOM,
                 10'h2a0, 10'h2b0, 10'h2c0, 1'b0};

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Data outputs also come out of reset at zero
    @(negedge clk);
    check_idle("reset");
    if (o_a_addr !== '0) begin
      report_mismatch("reset o_a_addr", o_a_addr, 32'h0);
    end
    if (o_b_addr !== '0) begin
      report_mismatch("reset o_b_addr", o_b_addr, 32'h0);
    end
    if (o_c_addr !== '0) begin
      report_mismatch("reset o_c_addr", o_c_addr, 32'h0);
    end
    if (o_c_data !== '0) begin
      report_mismatch("reset o_c_data", o_c_data, 32'h0);
    end

    for (int n = 0; n < NUM_TESTS; n++) begin
      run_test(tests[n]);
    end

    // Design must stay quiet once the last run is done
    repeat (3) begin
      @(negedge clk);
      check_idle("idle");
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             NUM_TESTS, tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/mac_pe.sv */
`default_nettype none

module mac_pe (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_acc
);
  import matmul_pkg::*;

  localparam prod_t PROD_HI = prod_t'(2 ** (DATA_W - 1) - 1);
  localparam prod_t PROD_LO = -prod_t'(2 ** (DATA_W - 1));

  elem_t a_q;
  elem_t b_q;
  prod_t prod_q;
  elem_t prod_sat;
  elem_t acc_q;

  // Operand regs double as the pass-through to the neighbours
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      acc_q  <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      prod_q <= a_q * b_q;
      acc_q  <= acc_q + prod_sat;
    end
  end

  // Clamp the full product to the element range
  always_comb begin
    if (prod_q > PROD_HI) begin
      prod_sat = PROD_HI[DATA_W-1:0];
    end else if (prod_q < PROD_LO) begin
      prod_sat = PROD_LO[DATA_W-1:0];
    end else begin
      prod_sat = prod_q[DATA_W-1:0];
    end
  end

  assign o_a   = a_q;
  assign o_b   = b_q;
  assign o_acc = acc_q;

endmodule

`default_nettype wire

/* source/matmul_4x4_top.sv */
`default_nettype none

module matmul_4x4_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_start,
  input  matmul_pkg::addr_t i_base_a,
  input  matmul_pkg::addr_t i_base_b,
  input  matmul_pkg::addr_t i_base_c,
  input  matmul_pkg::word_t i_a_data,
  input  matmul_pkg::word_t i_b_data,
  output logic              o_rd_en,
  output matmul_pkg::addr_t o_a_addr,
  output matmul_pkg::addr_t o_b_addr,
  output logic              o_c_valid,
  output matmul_pkg::addr_t o_c_addr,
  output matmul_pkg::word_t o_c_data,
  output logic              o_busy,
  output logic              o_done
);
  import matmul_pkg::*;

  phase_cnt_t count;
  logic       cnt_clear;
  logic       cnt_en;
  logic       array_clear;
  logic       wr_en;
  phase_cnt_t wr_col;
  addr_t      c_base;
  elem_t      acc [MAT_SIZE][MAT_SIZE];

  systolic_feed_if feed ();

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  matmul_ctrl_fsm u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .i_start     (i_start),
    .i_base_a    (i_base_a),
    .i_base_b    (i_base_b),
    .i_base_c    (i_base_c),
    .i_count     (count),
    .o_cnt_clear (cnt_clear),
    .o_cnt_en    (cnt_en),
    .o_rd_en     (o_rd_en),
    .o_a_addr    (o_a_addr),
    .o_b_addr    (o_b_addr),
    .o_clear     (array_clear),
    .o_wr_en     (wr_en),
    .o_wr_col    (wr_col),
    .o_c_base    (c_base),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  phase_counter u_counter (
    .clk     (clk),
    .reset   (reset),
    .i_clear (cnt_clear),
    .i_en    (cnt_en),
    .o_count (count)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  operand_skew u_skew (
    .clk      (clk),
    .reset    (reset),
    .i_rd_en  (o_rd_en),
    .i_clear  (array_clear),
    .i_a_data (i_a_data),
    .i_b_data (i_b_data),
    .feed     (feed.source)
  );

  pe_array u_array (
    .clk   (clk),
    .reset (reset),
    .feed  (feed.sink),
    .o_acc (acc)
  );

  result_writer u_writer (
    .clk       (clk),
    .reset     (reset),
    .i_wr_en   (wr_en),
    .i_wr_col  (wr_col),
    .i_c_base  (c_base),
    .i_acc     (acc),
    .o_c_valid (o_c_valid),
    .o_c_addr  (o_c_addr),
    .o_c_data  (o_c_data)
  );

endmodule

`default_nettype wire

/* source/matmul_ctrl_fsm.sv */
`default_nettype none

module matmul_ctrl_fsm (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::addr_t      i_base_a,
  input  matmul_pkg::addr_t      i_base_b,
  input  matmul_pkg::addr_t      i_base_c,
  input  matmul_pkg::phase_cnt_t i_count,
  output logic                   o_cnt_clear,
  output logic                   o_cnt_en,
  output logic                   o_rd_en,
  output matmul_pkg::addr_t      o_a_addr,
  output matmul_pkg::addr_t      o_b_addr,
  output logic                   o_clear,
  output logic                   o_wr_en,
  output matmul_pkg::phase_cnt_t o_wr_col,
  output matmul_pkg::addr_t      o_c_base,
  output logic                   o_busy,
  output logic                   o_done
);
  import matmul_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  addr_t       base_a;
  addr_t       base_b;
  addr_t       base_c;
  logic        last_fetch;
  logic        last_drain;
  logic        last_write;

  assign last_fetch = (i_count == phase_cnt_t'(MAT_SIZE - 1));
  assign last_drain = (i_count == phase_cnt_t'(DRAIN_CYCLES - 1));
  assign last_write = (i_count == phase_cnt_t'(MAT_SIZE - 1));

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (i_start) state_next = FETCH;
      FETCH:   if (last_fetch) state_next = DRAIN;
      DRAIN:   if (last_drain) state_next = WRITE;
      WRITE:   if (last_write) state_next = FINISH;
      FINISH:  state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Bases are sampled only when a run is accepted
  always_ff @(posedge clk) begin
    if (state == IDLE && i_start) begin
      base_a <= i_base_a;
      base_b <= i_base_b;
      base_c <= i_base_c;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Phase outputs
  //////////////////////////////////////////////////////////////////////

  assign o_cnt_clear = (state_next != state);
  assign o_cnt_en    = (state == FETCH) || (state == DRAIN) || (state == WRITE);
  assign o_rd_en     = (state == FETCH);
  assign o_a_addr    = o_rd_en ? base_a + addr_t'(i_count) : '0;
  assign o_b_addr    = o_rd_en ? base_b + addr_t'(i_count) : '0;
  assign o_clear     = (state == FETCH) && (i_count == '0);

  // The writer registers its word, so each capture is one cycle ahead of the write
  assign o_wr_en  = (state == DRAIN && last_drain) || (state == WRITE && !last_write);
  assign o_wr_col = (state == WRITE) ? i_count + 1'b1 : '0;
  assign o_c_base = base_c;

  assign o_busy = o_cnt_en;
  assign o_done = (state == FINISH);

  a_done_single : assert property (@(posedge clk) disable iff (reset)
    o_done |=> !o_done);

  a_rd_wr_apart : assert property (@(posedge clk) disable iff (reset)
    !(o_rd_en && o_wr_en));

  // First capture lands so that the C port writes in cycle WRITE_START
  a_write_start : assert property (@(posedge clk) disable iff (reset)
    (state == IDLE && i_start) |-> ##(WRITE_START - 1) o_wr_en);

endmodule

`default_nettype wire

/* source/matmul_pkg.sv */
`default_nettype none

package matmul_pkg;

  //////////////////////////////////////////////////////////////////////
  // Array geometry and memory timing
  //////////////////////////////////////////////////////////////////////

  localparam int MAT_SIZE    = 4;
  localparam int DATA_W      = 8;
  localparam int ADDR_W      = 10;
  localparam int MEM_LATENCY = 1;

  // Operand register, product register, accumulator
  localparam int MAC_STAGES = 3;

  // Memory latency + lane skew + travel across the array + MAC pipe
  localparam int DRAIN_CYCLES = MEM_LATENCY + (MAT_SIZE - 1) + (MAT_SIZE - 1) + MAC_STAGES;

  // Start cycle, then FETCH, then DRAIN
  localparam int WRITE_START = 1 + MAT_SIZE + DRAIN_CYCLES;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0]          elem_t;
  typedef logic signed [2*DATA_W-1:0]        prod_t;
  typedef logic        [MAT_SIZE*DATA_W-1:0] word_t;
  typedef logic        [ADDR_W-1:0]          addr_t;
  typedef logic        [3:0]                 phase_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DRAIN,
    WRITE,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

/* source/operand_skew.sv */
`default_nettype none

module operand_skew (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_rd_en,
  input  logic              i_clear,
  input  matmul_pkg::word_t i_a_data,
  input  matmul_pkg::word_t i_b_data,
  systolic_feed_if.source   feed
);
  import matmul_pkg::*;

  logic [MEM_LATENCY-1:0] rd_pipe;
  logic                   data_valid;
  elem_t                  a_gated [MAT_SIZE];
  elem_t                  b_gated [MAT_SIZE];

  // Read enable delayed by the memory latency marks valid data
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe[0] <= i_rd_en;
      for (int k = 1; k < MEM_LATENCY; k++) begin
        rd_pipe[k] <= rd_pipe[k-1];
      end
    end
  end

  assign data_valid = rd_pipe[MEM_LATENCY-1];

  always_comb begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      a_gated[i] = data_valid ? elem_t'(i_a_data[i*DATA_W +: DATA_W]) : '0;
      b_gated[i] = data_valid ? elem_t'(i_b_data[i*DATA_W +: DATA_W]) : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Triangular skew, lane i is i cycles late
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign feed.a_lane[i] = a_gated[i];
      assign feed.b_lane[i] = b_gated[i];
    end else begin : g_delay
      elem_t a_sr [i];
      elem_t b_sr [i];

      always_ff @(posedge clk) begin
        if (reset || i_clear) begin
          for (int k = 0; k < i; k++) begin
            a_sr[k] <= '0;
            b_sr[k] <= '0;
          end
        end else begin
          a_sr[0] <= a_gated[i];
          b_sr[0] <= b_gated[i];
          for (int k = 1; k < i; k++) begin
            a_sr[k] <= a_sr[k-1];
            b_sr[k] <= b_sr[k-1];
          end
        end
      end

      assign feed.a_lane[i] = a_sr[i-1];
      assign feed.b_lane[i] = b_sr[i-1];
    end
  end

  // Same cycle as the first fetch, ahead of any valid data
  assign feed.clear = i_clear;

endmodule

`default_nettype wire

/* source/pe_array.sv */
`default_nettype none

module pe_array (
  input  logic              clk,
  input  logic              reset,
  systolic_feed_if.sink     feed,
  output matmul_pkg::elem_t o_acc [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE]
);
  import matmul_pkg::*;

  // Column 0 of a_mesh and row 0 of b_mesh are the array edges
  elem_t a_mesh [MAT_SIZE][MAT_SIZE+1];
  elem_t b_mesh [MAT_SIZE+1][MAT_SIZE];

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_edge
    assign a_mesh[i][0] = feed.a_lane[i];
    assign b_mesh[0][i] = feed.b_lane[i];
  end

  //////////////////////////////////////////////////////////////////////
  // a flows right, b flows down, one cycle per PE
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (feed.clear),
        .i_a     (a_mesh[i][j]),
        .i_b     (b_mesh[i][j]),
        .o_a     (a_mesh[i][j+1]),
        .o_b     (b_mesh[i+1][j]),
        .o_acc   (o_acc[i][j])
      );
    end
  end

endmodule

`default_nettype wire

/* source/phase_counter.sv */
`default_nettype none

module phase_counter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_clear,
  input  logic                   i_en,
  output matmul_pkg::phase_cnt_t o_count
);
  import matmul_pkg::*;

  localparam phase_cnt_t CNT_MAX = '1;

  // Holds at the top value rather than wrapping
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_count <= '0;
    end else if (i_en && o_count != CNT_MAX) begin
      o_count <= o_count + 1'b1;
    end
  end

  // Every phase must end before the counter could saturate
  a_no_saturation : assert property (@(posedge clk) disable iff (reset)
    i_en |-> o_count != CNT_MAX);

endmodule

`default_nettype wire

/* source/result_writer.sv */
`default_nettype none

module result_writer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_wr_en,
  input  matmul_pkg::phase_cnt_t i_wr_col,
  input  matmul_pkg::addr_t      i_c_base,
  input  matmul_pkg::elem_t      i_acc [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE],
  output logic                   o_c_valid,
  output matmul_pkg::addr_t      o_c_addr,
  output matmul_pkg::word_t      o_c_data
);
  import matmul_pkg::*;

  localparam int COL_W = $clog2(MAT_SIZE);

  word_t col_word;

  // Lane i of the word is row i of the selected column
  always_comb begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      col_word[i*DATA_W +: DATA_W] = i_acc[i][i_wr_col[COL_W-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_c_valid <= 1'b0;
      o_c_addr  <= '0;
      o_c_data  <= '0;
    end else begin
      o_c_valid <= i_wr_en;
      if (i_wr_en) begin
        o_c_addr <= i_c_base + addr_t'(i_wr_col);
        o_c_data <= col_word;
      end
    end
  end

  a_burst_len : assert property (@(posedge clk) disable iff (reset)
    o_c_valid [* MAT_SIZE] |=> !o_c_valid);

endmodule

`default_nettype wire

/* source/systolic_feed_if.sv */
`default_nettype none

// Skewed operand lanes entering the left and top edges of the array
interface systolic_feed_if;
  import matmul_pkg::*;

  // One lane per array row
  elem_t a_lane [MAT_SIZE];
  // One lane per array column
  elem_t b_lane [MAT_SIZE];
  // Zeroes every PE register for a new run
  logic  clear;

  modport source (
    output a_lane,
    output b_lane,
    output clear
  );

  modport sink (
    input a_lane,
    input b_lane,
    input clear
  );

endinterface

`default_nettype wire

/* tb.f */
source/matmul_pkg.sv
source/systolic_feed_if.sv
source/matmul_ctrl_fsm.sv
source/phase_counter.sv
source/operand_skew.sv
source/mac_pe.sv
source/pe_array.sv
source/result_writer.sv
source/matmul_4x4_top.sv
dv/clock_gen.sv
dv/matmul_tb.sv
